// ==== core_defs.svh ====
// Core-wide constants shared by the RTL and the testbench, pulled in with `include
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Datapath and address width
`define CORE_XLEN 32

// First PC fetched after reset
`define CORE_RESET_PC 32'h0000_0000

// Sequential PC increment
`define CORE_PC_STEP 32'd4

// Instruction memory size in words
`define CORE_IMEM_DEPTH 256

// Cycles from rd_req to rd_valid
`define CORE_IMEM_LATENCY 2

// Full ebreak encoding, stops the core
`define CORE_EBREAK 32'h0010_0073

`endif

// ==== rv_isa_pkg.sv ====
// RV32I encoding types for the supported subset, imported by decode and execute
`default_nettype none

package rv_isa_pkg;

  // Major opcodes, bits [6:0]
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b001_0011,
    OPC_OP     = 7'b011_0011,
    OPC_LUI    = 7'b011_0111,
    OPC_BRANCH = 7'b110_0011,
    OPC_JAL    = 7'b110_1111,
    OPC_JALR   = 7'b110_0111,
    OPC_SYSTEM = 7'b111_0011
  } opcode_e;

  // funct3 codes, bits [14:12]
  // beq, jalr and ebreak share the add code
  typedef enum logic [2:0] {
    F3_ADD = 3'b000,
    F3_BNE = 3'b001,
    F3_XOR = 3'b100,
    F3_OR  = 3'b110,
    F3_AND = 3'b111
  } funct3_e;

  // funct7 field, bits [31:25]
  typedef logic [6:0] funct7_t;

  localparam funct7_t F7_BASE = 7'b000_0000;
  // Selects sub instead of add
  localparam funct7_t F7_ALT  = 7'b010_0000;

  // Immediate after sign extension
  typedef logic [31:0] imm_t;

endpackage

`default_nettype wire

// ==== core_pkg.sv ====
// Microarchitecture types of the core: datapath words and control enums
`default_nettype none

`include "core_defs.svh"

package core_pkg;

  typedef logic [`CORE_XLEN-1:0] word_t;
  typedef logic [`CORE_XLEN-1:0] pc_t;
  typedef logic [4:0]            reg_idx_t;

  // Next-PC source, registered by writeback
  typedef enum logic [2:0] {
    PC_SEQ    = 3'd0,
    PC_JALR   = 3'd1,
    PC_BRANCH = 3'd2,
    PC_JAL    = 3'd3
  } pc_sel_e;

  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_PASS_B = 3'd5
  } alu_op_e;

  // Fetch FSM states
  typedef enum logic [1:0] {
    FS_IDLE       = 2'd0,
    FS_FETCH_REQ  = 2'd1,
    FS_FETCH_WAIT = 2'd2,
    FS_FETCH_DONE = 2'd3
  } fetch_state_e;

endpackage

`default_nettype wire

// ==== inst_mem.sv ====
// Instruction memory with a program-load port and fixed-latency reads for the fetch unit
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module inst_mem
  import core_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  prog_we,
  input  pc_t   prog_addr,
  input  word_t prog_data,
  input  logic  rd_req,
  input  pc_t   rd_addr,
  output logic  rd_valid,
  output word_t rd_data
);

  localparam int IDX_W = $clog2(`CORE_IMEM_DEPTH);
  localparam int LAT   = `CORE_IMEM_LATENCY;

  word_t          mem [`CORE_IMEM_DEPTH];
  logic [LAT-1:0] req_sr;

  // Byte address to word index
  always_ff @(posedge clk) begin
    if (prog_we) begin
      mem[prog_addr[IDX_W+1:2]] <= prog_data;
    end
    if (rd_req) begin
      rd_data <= mem[rd_addr[IDX_W+1:2]];
    end
  end

  // Request strobe delayed by the read latency
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      req_sr <= '0;
    end else begin
      req_sr[0] <= rd_req;
      for (int i = 1; i < LAT; i++) begin
        req_sr[i] <= req_sr[i-1];
      end
    end
  end

  assign rd_valid = req_sr[LAT-1];

endmodule

`default_nettype wire

// ==== inst_fetch.sv ====
// Fetch unit: PC register, next-PC mux and the FSM that hands instructions to decode
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module inst_fetch
  import core_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  pc_sel_e pc_sel,
  input  pc_t     jalr_target,
  input  pc_t     br_target,
  input  pc_t     jal_target,
  input  logic    pc_wen,
  input  logic    idu_ready,
  input  logic    rd_valid,
  input  word_t   rd_data,
  output pc_t     pc,
  output word_t   inst,
  output logic    inst_valid,
  output logic    rd_req
);

  fetch_state_e state_q;
  pc_t          pc_q;
  pc_t          pc_plus4;
  pc_t          pc_next;
  word_t        inst_buf;

  assign pc_plus4 = pc_q + `CORE_PC_STEP;

  always_comb begin
    case (pc_sel)
      PC_JALR:   pc_next = jalr_target;
      PC_BRANCH: pc_next = br_target;
      PC_JAL:    pc_next = jal_target;
      default:   pc_next = pc_plus4;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc_q <= `CORE_RESET_PC;
    end else if (pc_wen) begin
      pc_q <= pc_next;
    end
  end

  // First fetch after reset needs no pc_wen
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q    <= FS_FETCH_REQ;
      rd_req     <= 1'b0;
      inst_valid <= 1'b0;
    end else begin
      case (state_q)
        FS_IDLE: begin
          if (pc_wen) begin
            state_q <= FS_FETCH_REQ;
          end
        end
        FS_FETCH_REQ: begin
          rd_req  <= 1'b1;
          state_q <= FS_FETCH_WAIT;
        end
        FS_FETCH_WAIT: begin
          rd_req <= 1'b0;
          if (rd_valid) begin
            inst_valid <= 1'b1;
            state_q    <= FS_FETCH_DONE;
          end
        end
        FS_FETCH_DONE: begin
          // Held here while decode is stalled
          if (idu_ready) begin
            inst_valid <= 1'b0;
            state_q    <= FS_IDLE;
          end
        end
        default: begin
          rd_req     <= 1'b0;
          inst_valid <= 1'b0;
          state_q    <= FS_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == FS_FETCH_WAIT && rd_valid) begin
      inst_buf <= rd_data;
    end
  end

  assign pc   = pc_q;
  assign inst = inst_buf;

endmodule

`default_nettype wire

// ==== inst_decode.sv ====
// Decode stage: instruction fields, immediates and control signals, stalls fetch once halted
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module inst_decode
  import core_pkg::*;
  import rv_isa_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  word_t    inst,
  input  logic     inst_valid,
  output logic     idu_ready,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output reg_idx_t rd,
  output imm_t     imm,
  output alu_op_e  alu_op,
  output logic     use_imm,
  output logic     reg_we,
  output logic     is_branch,
  output logic     branch_ne,
  output logic     is_jal,
  output logic     is_jalr,
  output logic     is_ebreak
);

  opcode_e opcode;
  funct3_e funct3;
  funct7_t funct7;
  imm_t    imm_i;
  imm_t    imm_u;
  imm_t    imm_b;
  imm_t    imm_j;
  alu_op_e alu_f3;
  logic    f3_ok;
  logic    halted_q;

  assign opcode = opcode_e'(inst[6:0]);
  assign funct3 = funct3_e'(inst[14:12]);
  assign funct7 = inst[31:25];
  assign rd     = inst[11:7];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  assign is_ebreak = (inst == `CORE_EBREAK);

  // Logic op shared by register and immediate forms
  always_comb begin
    f3_ok  = 1'b1;
    alu_f3 = ALU_ADD;
    case (funct3)
      F3_ADD:  alu_f3 = ALU_ADD;
      F3_XOR:  alu_f3 = ALU_XOR;
      F3_OR:   alu_f3 = ALU_OR;
      F3_AND:  alu_f3 = ALU_AND;
      default: f3_ok = 1'b0;
    endcase
  end

  // Anything unrecognized falls through as a no-op
  always_comb begin
    imm       = imm_i;
    alu_op    = ALU_ADD;
    use_imm   = 1'b0;
    reg_we    = 1'b0;
    is_branch = 1'b0;
    branch_ne = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    case (opcode)
      OPC_OP_IMM: begin
        use_imm = 1'b1;
        alu_op  = alu_f3;
        reg_we  = f3_ok;
      end
      OPC_OP: begin
        if (funct7 == F7_BASE) begin
          alu_op = alu_f3;
          reg_we = f3_ok;
        end else if (funct7 == F7_ALT && funct3 == F3_ADD) begin
          alu_op = ALU_SUB;
          reg_we = 1'b1;
        end
      end
      OPC_LUI: begin
        imm     = imm_u;
        use_imm = 1'b1;
        alu_op  = ALU_PASS_B;
        reg_we  = 1'b1;
      end
      OPC_BRANCH: begin
        imm       = imm_b;
        is_branch = (funct3 == F3_ADD) || (funct3 == F3_BNE);
        branch_ne = (funct3 == F3_BNE);
      end
      OPC_JAL: begin
        imm    = imm_j;
        is_jal = 1'b1;
        reg_we = 1'b1;
      end
      OPC_JALR: begin
        is_jalr = (funct3 == F3_ADD);
        reg_we  = (funct3 == F3_ADD);
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      halted_q <= 1'b0;
    end else if (inst_valid && idu_ready && is_ebreak) begin
      halted_q <= 1'b1;
    end
  end

  assign idu_ready = ~halted_q;

endmodule

`default_nettype wire

// ==== execute_unit.sv ====
// Execute stage: ALU, branch compare, link value and jump and branch targets
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module execute_unit
  import core_pkg::*;
  import rv_isa_pkg::*;
(
  input  pc_t     pc,
  input  word_t   rs1_val,
  input  word_t   rs2_val,
  input  imm_t    imm,
  input  alu_op_e alu_op,
  input  logic    use_imm,
  input  logic    is_branch,
  input  logic    branch_ne,
  input  logic    is_jal,
  input  logic    is_jalr,
  output word_t   result,
  output pc_sel_e pc_sel,
  output pc_t     jalr_target,
  output pc_t     br_target,
  output pc_t     jal_target
);

  word_t op_b;
  word_t alu_out;
  logic  taken;

  assign op_b = use_imm ? imm : rs2_val;

  always_comb begin
    case (alu_op)
      ALU_SUB:    alu_out = rs1_val - op_b;
      ALU_AND:    alu_out = rs1_val & op_b;
      ALU_OR:     alu_out = rs1_val | op_b;
      ALU_XOR:    alu_out = rs1_val ^ op_b;
      ALU_PASS_B: alu_out = op_b;
      default:    alu_out = rs1_val + op_b;
    endcase
  end

  // Jumps write the return address
  assign result = (is_jal || is_jalr) ? pc + `CORE_PC_STEP : alu_out;

  assign taken = is_branch && ((rs1_val == rs2_val) ^ branch_ne);

  assign jalr_target = (rs1_val + imm) & ~pc_t'(1);
  assign br_target   = pc + imm;
  assign jal_target  = pc + imm;

  always_comb begin
    if (is_jal) begin
      pc_sel = PC_JAL;
    end else if (is_jalr) begin
      pc_sel = PC_JALR;
    end else if (taken) begin
      pc_sel = PC_BRANCH;
    end else begin
      pc_sel = PC_SEQ;
    end
  end

endmodule

`default_nettype wire

// ==== write_back.sv ====
// Writeback stage: register file, retire report, halt flag and next-PC handoff to fetch
`timescale 1ns/1ps
`default_nettype none

module write_back
  import core_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     accept,
  input  pc_t      pc,
  input  reg_idx_t rd,
  input  logic     reg_we,
  input  word_t    result,
  input  logic     is_ebreak,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  pc_sel_e  pc_sel_in,
  input  pc_t      jalr_target,
  input  pc_t      br_target,
  input  pc_t      jal_target,
  output word_t    rs1_val,
  output word_t    rs2_val,
  output logic     pc_wen,
  output pc_sel_e  pc_sel,
  output pc_t      jalr_target_q,
  output pc_t      br_target_q,
  output pc_t      jal_target_q,
  output logic     retire_valid,
  output pc_t      retire_pc,
  output reg_idx_t retire_rd,
  output word_t    retire_data,
  output logic     halted
);

  word_t rf [32];
  logic  commit;
  logic  wr_en;

  assign commit = accept && !is_ebreak;
  // x0 writes are dropped
  assign wr_en  = commit && reg_we && (rd != '0);

  assign rs1_val = (rs1 == '0) ? '0 : rf[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : rf[rs2];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      rf[rd] <= result;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc_wen       <= 1'b0;
      pc_sel       <= PC_SEQ;
      retire_valid <= 1'b0;
      halted       <= 1'b0;
    end else begin
      pc_wen       <= commit;
      retire_valid <= commit;
      if (commit) begin
        pc_sel <= pc_sel_in;
      end
      // ebreak stops here, no pc_wen so fetch stays idle
      if (accept && is_ebreak) begin
        halted <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (commit) begin
      jalr_target_q <= jalr_target;
      br_target_q   <= br_target;
      jal_target_q  <= jal_target;
      retire_pc     <= pc;
      retire_rd     <= wr_en ? rd : '0;
      retire_data   <= wr_en ? result : '0;
    end
  end

endmodule

`default_nettype wire

// ==== mini_core.sv ====
// Top level of the multi-cycle core, instantiated by the testbench as the DUT
`timescale 1ns/1ps
`default_nettype none

module mini_core
  import core_pkg::*;
  import rv_isa_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     prog_we,
  input  pc_t      prog_addr,
  input  word_t    prog_data,
  output logic     retire_valid,
  output pc_t      retire_pc,
  output reg_idx_t retire_rd,
  output word_t    retire_data,
  output logic     halted
);

  // Fetch and memory
  logic     rd_req;
  logic     rd_valid;
  word_t    rd_data;
  pc_t      pc;
  word_t    inst;
  logic     inst_valid;
  logic     idu_ready;
  logic     accept;

  // Decode
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  imm_t     imm;
  alu_op_e  alu_op;
  logic     use_imm;
  logic     reg_we;
  logic     is_branch;
  logic     branch_ne;
  logic     is_jal;
  logic     is_jalr;
  logic     is_ebreak;

  // Execute and writeback
  word_t    rs1_val;
  word_t    rs2_val;
  word_t    result;
  pc_sel_e  ex_pc_sel;
  pc_t      ex_jalr_target;
  pc_t      ex_br_target;
  pc_t      ex_jal_target;
  pc_sel_e  wb_pc_sel;
  pc_t      wb_jalr_target;
  pc_t      wb_br_target;
  pc_t      wb_jal_target;
  logic     pc_wen;

  assign accept = inst_valid && idu_ready;

  inst_mem u_inst_mem (
    .clk       (clk),
    .rst       (rst),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .rd_req    (rd_req),
    .rd_addr   (pc),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data)
  );

  inst_fetch u_inst_fetch (
    .clk         (clk),
    .rst         (rst),
    .pc_sel      (wb_pc_sel),
    .jalr_target (wb_jalr_target),
    .br_target   (wb_br_target),
    .jal_target  (wb_jal_target),
    .pc_wen      (pc_wen),
    .idu_ready   (idu_ready),
    .rd_valid    (rd_valid),
    .rd_data     (rd_data),
    .pc          (pc),
    .inst        (inst),
    .inst_valid  (inst_valid),
    .rd_req      (rd_req)
  );

  inst_decode u_inst_decode (
    .clk        (clk),
    .rst        (rst),
    .inst       (inst),
    .inst_valid (inst_valid),
    .idu_ready  (idu_ready),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .imm        (imm),
    .alu_op     (alu_op),
    .use_imm    (use_imm),
    .reg_we     (reg_we),
    .is_branch  (is_branch),
    .branch_ne  (branch_ne),
    .is_jal     (is_jal),
    .is_jalr    (is_jalr),
    .is_ebreak  (is_ebreak)
  );

  execute_unit u_execute_unit (
    .pc          (pc),
    .rs1_val     (rs1_val),
    .rs2_val     (rs2_val),
    .imm         (imm),
    .alu_op      (alu_op),
    .use_imm     (use_imm),
    .is_branch   (is_branch),
    .branch_ne   (branch_ne),
    .is_jal      (is_jal),
    .is_jalr     (is_jalr),
    .result      (result),
    .pc_sel      (ex_pc_sel),
    .jalr_target (ex_jalr_target),
    .br_target   (ex_br_target),
    .jal_target  (ex_jal_target)
  );

  write_back u_write_back (
    .clk           (clk),
    .rst           (rst),
    .accept        (accept),
    .pc            (pc),
    .rd            (rd),
    .reg_we        (reg_we),
    .result        (result),
    .is_ebreak     (is_ebreak),
    .rs1           (rs1),
    .rs2           (rs2),
    .pc_sel_in     (ex_pc_sel),
    .jalr_target   (ex_jalr_target),
    .br_target     (ex_br_target),
    .jal_target    (ex_jal_target),
    .rs1_val       (rs1_val),
    .rs2_val       (rs2_val),
    .pc_wen        (pc_wen),
    .pc_sel        (wb_pc_sel),
    .jalr_target_q (wb_jalr_target),
    .br_target_q   (wb_br_target),
    .jal_target_q  (wb_jal_target),
    .retire_valid  (retire_valid),
    .retire_pc     (retire_pc),
    .retire_rd     (retire_rd),
    .retire_data   (retire_data),
    .halted        (halted)
  );

endmodule

`default_nettype wire

// ==== tb_mini_core.sv ====
// Directed testbench for mini_core: loads small programs and checks retire reports against a model
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module tb_mini_core
  import core_pkg::*;
();

  localparam int DEPTH        = `CORE_IMEM_DEPTH;
  localparam int IDX_W        = $clog2(DEPTH);
  localparam int RST_CYCLES   = 8;
  localparam int WAIT_LIMIT   = 100;
  localparam int QUIET_CYCLES = 40;
  localparam int MAX_STEPS    = 100;

  // RV32I major opcodes
  localparam logic [6:0] MAJ_OP_IMM = 7'b001_0011;
  localparam logic [6:0] MAJ_OP     = 7'b011_0011;
  localparam logic [6:0] MAJ_LUI    = 7'b011_0111;
  localparam logic [6:0] MAJ_BRANCH = 7'b110_0011;
  localparam logic [6:0] MAJ_JAL    = 7'b110_1111;
  localparam logic [6:0] MAJ_JALR   = 7'b110_0111;

  // First nine entries are the ALU kinds picked by the random program
  typedef enum int {
    K_ADDI, K_ANDI, K_ORI, K_XORI, K_ADD, K_SUB, K_AND, K_OR, K_XOR,
    K_LUI, K_BEQ, K_BNE, K_JAL, K_JALR, K_EBREAK
  } kind_e;

  logic     clk;
  logic     rst;
  logic     prog_we;
  pc_t      prog_addr;
  word_t    prog_data;
  logic     retire_valid;
  pc_t      retire_pc;
  reg_idx_t retire_rd;
  word_t    retire_data;
  logic     halted;

  // Program image as fields, one entry per word
  kind_e    pk   [DEPTH];
  reg_idx_t prd  [DEPTH];
  reg_idx_t prs1 [DEPTH];
  reg_idx_t prs2 [DEPTH];
  word_t    pimm [DEPTH];
  int       prog_len;

  // Register file has no reset, so the model carries over between tests
  word_t    regs [32];
  word_t    lcg_state;
  int       err_count;

  mini_core dut (
    .clk          (clk),
    .rst          (rst),
    .prog_we      (prog_we),
    .prog_addr    (prog_addr),
    .prog_data    (prog_data),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .halted       (halted)
  );

  always #4 clk = ~clk;

  task automatic stop_run();
    err_count++;
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic word_t rand_imm12();
    word_t r;
    r = lcg_next();
    return {{20{r[27]}}, r[27:16]};
  endfunction

  function automatic int rand_below(int n);
    word_t r;
    r = lcg_next();
    return int'((r >> 8) % word_t'(n));
  endfunction

  // Standard RV32I encodings
  function automatic word_t encode(kind_e k, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2,
                                   word_t imm);
    word_t w;
    case (k)
      K_ADDI:  w = {imm[11:0], rs1, 3'b000, rd, MAJ_OP_IMM};
      K_ANDI:  w = {imm[11:0], rs1, 3'b111, rd, MAJ_OP_IMM};
      K_ORI:   w = {imm[11:0], rs1, 3'b110, rd, MAJ_OP_IMM};
      K_XORI:  w = {imm[11:0], rs1, 3'b100, rd, MAJ_OP_IMM};
      K_ADD:   w = {7'b000_0000, rs2, rs1, 3'b000, rd, MAJ_OP};
      K_SUB:   w = {7'b010_0000, rs2, rs1, 3'b000, rd, MAJ_OP};
      K_AND:   w = {7'b000_0000, rs2, rs1, 3'b111, rd, MAJ_OP};
      K_OR:    w = {7'b000_0000, rs2, rs1, 3'b110, rd, MAJ_OP};
      K_XOR:   w = {7'b000_0000, rs2, rs1, 3'b100, rd, MAJ_OP};
      K_LUI:   w = {imm[31:12], rd, MAJ_LUI};
      K_BEQ:   w = {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], MAJ_BRANCH};
      K_BNE:   w = {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], MAJ_BRANCH};
      K_JAL:   w = {imm[20], imm[10:1], imm[11], imm[19:12], rd, MAJ_JAL};
      K_JALR:  w = {imm[11:0], rs1, 3'b000, rd, MAJ_JALR};
      default: w = `CORE_EBREAK;
    endcase
    return w;
  endfunction

  task automatic emit(kind_e k, int rd, int rs1, int rs2, word_t imm);
    pk[prog_len]   = k;
    prd[prog_len]  = 5'(rd);
    prs1[prog_len] = 5'(rs1);
    prs2[prog_len] = 5'(rs2);
    pimm[prog_len] = imm;
    prog_len++;
  endtask

  // One instruction of the reference model, in retire order
  task automatic model_step(input pc_t pc, output pc_t npc, output reg_idx_t exp_rd,
                            output word_t exp_data);
    logic [IDX_W-1:0] idx;
    word_t a;
    word_t b;
    word_t imm;
    word_t val;
    logic  wr;
    idx = pc[IDX_W+1:2];
    a   = regs[prs1[idx]];
    b   = regs[prs2[idx]];
    imm = pimm[idx];
    val = '0;
    wr  = 1'b1;
    npc = pc + `CORE_PC_STEP;
    case (pk[idx])
      K_ADDI: val = a + imm;
      K_ANDI: val = a & imm;
      K_ORI:  val = a | imm;
      K_XORI: val = a ^ imm;
      K_ADD:  val = a + b;
      K_SUB:  val = a - b;
      K_AND:  val = a & b;
      K_OR:   val = a | b;
      K_XOR:  val = a ^ b;
      K_LUI:  val = imm;
      K_BEQ: begin
        wr = 1'b0;
        if (a == b) begin
          npc = pc + imm;
        end
      end
      K_BNE: begin
        wr = 1'b0;
        if (a != b) begin
          npc = pc + imm;
        end
      end
      K_JAL: begin
        val = pc + `CORE_PC_STEP;
        npc = pc + imm;
      end
      K_JALR: begin
        val = pc + `CORE_PC_STEP;
        npc = (a + imm) & 32'hFFFF_FFFE;
      end
      default: wr = 1'b0;
    endcase
    if (wr && prd[idx] != 5'd0) begin
      regs[prd[idx]] = val;
      exp_rd         = prd[idx];
      exp_data       = val;
    end else begin
      exp_rd   = '0;
      exp_data = '0;
    end
  endtask

  // Program goes in through the load port while the core sits in reset
  task automatic load_and_reset();
    int i;
    @(posedge clk);
    #1;
    rst = 1'b1;
    for (i = 0; i < prog_len || i < RST_CYCLES; i++) begin
      if (i < prog_len) begin
        prog_we   = 1'b1;
        prog_addr = pc_t'(i * 4);
        prog_data = encode(pk[i], prd[i], prs1[i], prs2[i], pimm[i]);
      end else begin
        prog_we = 1'b0;
      end
      @(posedge clk);
      #1;
    end
    prog_we = 1'b0;
    rst     = 1'b0;
    assert (retire_valid === 1'b0 && halted === 1'b0) else begin
      $display("retire_valid or halted is high right after reset");
      stop_run();
    end
  endtask

  task automatic wait_retire();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
      assert (n <= WAIT_LIMIT) else begin
        $display("timeout waiting for retire_valid");
        stop_run();
      end
    end while (retire_valid !== 1'b1);
  endtask

  task automatic wait_halt();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
      assert (n <= WAIT_LIMIT) else begin
        $display("timeout waiting for halted after ebreak");
        stop_run();
      end
    end while (halted !== 1'b1);
  endtask

  // Runs the loaded program up to its ebreak, checking every retire report
  task automatic run_program();
    pc_t      mpc;
    pc_t      npc;
    reg_idx_t exp_rd;
    word_t    exp_data;
    int       steps;
    int       n;
    load_and_reset();
    mpc   = `CORE_RESET_PC;
    steps = 0;
    while (pk[mpc[IDX_W+1:2]] != K_EBREAK) begin
      model_step(mpc, npc, exp_rd, exp_data);
      wait_retire();
      assert (retire_pc === mpc) else begin
        $display("ERROR retire_pc: got %h, expected %h", retire_pc, mpc);
        stop_run();
      end
      assert (retire_rd === exp_rd) else begin
        $display("ERROR retire_rd: got %h, expected %h", retire_rd, exp_rd);
        stop_run();
      end
      assert (retire_data === exp_data) else begin
        $display("ERROR retire_data: got %h, expected %h", retire_data, exp_data);
        stop_run();
      end
      assert (halted === 1'b0) else begin
        $display("ERROR halted: got %h, expected 0", halted);
        stop_run();
      end
      mpc = npc;
      steps++;
      assert (steps < MAX_STEPS) else begin
        $display("program did not reach its ebreak");
        stop_run();
      end
    end
    wait_halt();
    // Words after ebreak must never retire
    for (n = 0; n < QUIET_CYCLES; n++) begin
      @(posedge clk);
      #1;
      assert (retire_valid === 1'b0) else begin
        $display("an instruction retired after ebreak at pc %h", retire_pc);
        stop_run();
      end
      assert (halted === 1'b1) else begin
        $display("ERROR halted: got %h, expected 1", halted);
        stop_run();
      end
    end
  endtask

  task automatic alu_ops_test();
    prog_len = 0;
    emit(K_ADDI, 1, 0, 0, rand_imm12());
    emit(K_ADDI, 2, 0, 0, rand_imm12());
    emit(K_ANDI, 3, 1, 0, rand_imm12());
    emit(K_ORI, 4, 2, 0, rand_imm12());
    emit(K_XORI, 5, 1, 0, rand_imm12());
    emit(K_ADD, 6, 1, 2, 0);
    emit(K_SUB, 7, 3, 4, 0);
    emit(K_AND, 8, 5, 2, 0);
    emit(K_OR, 9, 6, 7, 0);
    emit(K_XOR, 10, 8, 9, 0);
    emit(K_EBREAK, 0, 0, 0, 0);
    run_program();
  endtask

  task automatic x0_lui_test();
    prog_len = 0;
    emit(K_ADDI, 0, 0, 0, 123);
    emit(K_ADD, 11, 0, 0, 0);
    emit(K_LUI, 12, 0, 0, 32'hABCD_E000);
    emit(K_ADDI, 13, 12, 0, 32'h0000_07FF);
    emit(K_LUI, 0, 0, 0, 32'h1234_5000);
    emit(K_OR, 14, 0, 12, 0);
    emit(K_EBREAK, 0, 0, 0, 0);
    run_program();
  endtask

  task automatic branch_test();
    prog_len = 0;
    emit(K_ADDI, 1, 0, 0, 5);
    emit(K_ADDI, 2, 0, 0, 5);
    emit(K_ADDI, 3, 0, 0, 7);
    emit(K_BEQ, 0, 1, 2, 8);
    emit(K_ADDI, 4, 0, 0, 1);
    emit(K_BEQ, 0, 1, 3, 8);
    emit(K_BNE, 0, 1, 3, 12);
    emit(K_ADDI, 4, 0, 0, 2);
    emit(K_ADDI, 4, 0, 0, 3);
    emit(K_BNE, 0, 1, 2, 8);
    // Short countdown loop with a backward branch
    emit(K_ADDI, 6, 0, 0, 2);
    emit(K_ADDI, 6, 6, 0, -1);
    emit(K_BNE, 0, 6, 0, -4);
    emit(K_EBREAK, 0, 0, 0, 0);
    run_program();
  endtask

  task automatic jump_test();
    prog_len = 0;
    emit(K_ADDI, 1, 0, 0, 33);
    emit(K_JAL, 2, 0, 0, 12);
    emit(K_ADDI, 3, 0, 0, 1);
    emit(K_ADDI, 3, 0, 0, 2);
    // Odd target, bit 0 is dropped
    emit(K_JALR, 4, 1, 0, -4);
    emit(K_ADDI, 3, 0, 0, 3);
    emit(K_ADDI, 3, 0, 0, 4);
    emit(K_JAL, 0, 0, 0, 8);
    emit(K_ADDI, 3, 0, 0, 5);
    emit(K_JALR, 5, 4, 0, 20);
    emit(K_EBREAK, 0, 0, 0, 0);
    run_program();
  endtask

  task automatic ebreak_test();
    prog_len = 0;
    emit(K_ADDI, 15, 0, 0, 77);
    emit(K_EBREAK, 0, 0, 0, 0);
    emit(K_ADDI, 15, 0, 0, 1);
    emit(K_ADDI, 16, 0, 0, 2);
    emit(K_ADD, 17, 15, 16, 0);
    run_program();
  endtask

  // Straight-line code, so each retire_pc must be the previous one plus 4
  task automatic ordering_test();
    int    i;
    kind_e k;
    int    rd;
    int    rs1;
    int    rs2;
    prog_len = 0;
    // Seed x1..x4 so every random source is defined
    for (i = 1; i <= 4; i++) begin
      emit(K_ADDI, i, 0, 0, rand_imm12());
    end
    for (i = 4; i < 20; i++) begin
      k   = kind_e'(rand_below(9));
      rd  = 1 + rand_below(4);
      rs1 = 1 + rand_below(4);
      rs2 = 1 + rand_below(4);
      emit(k, rd, rs1, rs2, rand_imm12());
    end
    emit(K_EBREAK, 0, 0, 0, 0);
    run_program();
  endtask

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    prog_len  = 0;
    err_count = 0;
    lcg_state = 32'd11079;
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
    end
    alu_ops_test();
    x0_lui_test();
    branch_test();
    jump_test();
    ebreak_test();
    ordering_test();
    if (err_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== mini_core.f ====
+incdir+.
rv_isa_pkg.sv
core_pkg.sv
inst_mem.sv
inst_fetch.sv
inst_decode.sv
execute_unit.sv
write_back.sv
mini_core.sv
tb_mini_core.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_mini_core -f mini_core.f \
  -o sim_mini_core && ./obj_dir/sim_mini_core > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST FAILED" sim.log 2>/dev/null && { echo "simulation reported failure"; exit 1; }
grep -q "TEST PASSED" sim.log 2>/dev/null || { echo "simulation did not complete"; exit 1; }
exit 0
